/* logic/rd_pkg.sv */
// Shared widths, limits and types for the AXI4 read master
// Data path is 32 bits and bursts never cross a 1 KB boundary
// Burst length is capped by the 256 beat AXI4 limit and the 4 KB page
// A byte count of zero is not supported
package rd_pkg;

  //////////////////////////////
  // Interface widths
  //////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int XFER_W = 32;

  // Bytes carried by one data beat
  localparam int DW_BYTES = DATA_W / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  //////////////////////////////
  // Burst geometry
  //////////////////////////////
  // Full burst is the smaller of 256 beats and one 4 KB page
  localparam int BURST_BEATS = (4096 / DW_BYTES < 256) ? 4096 / DW_BYTES : 256;
  localparam int LOG_BURST = $clog2(BURST_BEATS);
  // Address step between consecutive bursts
  localparam int BURST_BYTES = BURST_BEATS * DW_BYTES;

  // Outstanding burst limit and the width of its vacancy count
  localparam int MAX_OUTSTANDING = 4;
  localparam int OUTST_W = $clog2(MAX_OUTSTANDING + 1);

  // Total beats minus one, then bursts minus one
  localparam int TOTAL_LEN_W = XFER_W - LOG_DW_BYTES;
  localparam int TXN_W = TOTAL_LEN_W - LOG_BURST;

  //////////////////////////////
  // Vector types
  //////////////////////////////
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [XFER_W-1:0] xfer_size_t;
  // AXI length field holds beats minus one
  typedef logic [LOG_BURST-1:0] arlen_t;
  typedef logic [TXN_W-1:0] txn_cnt_t;
  typedef logic [OUTST_W-1:0] outst_cnt_t;

  //////////////////////////////
  // Structs
  //////////////////////////////
  // Pre-processed command handed to the issuer and the tracker
  typedef struct packed {
    addr_t    base_addr;
    txn_cnt_t last_txn;
    arlen_t   final_len;
  } burst_plan_t;

  // AR channel payload
  typedef struct packed {
    addr_t  addr;
    arlen_t len;
  } ar_req_t;

  // R channel payload, reused unchanged on the stream side
  typedef struct packed {
    data_t data;
    logic  last;
  } r_beat_t;

endpackage

/* logic/rd_cmd_regs.sv */
// Captures a start request and turns it into a burst plan
// Inputs are sampled only in the cycle where ctrl_start is high
// The start address is forced down to a burst boundary
// A new start must wait for the previous done pulse
module rd_cmd_regs (
  input  logic                 aclk,
  input  logic                 areset,
  input  logic                 ctrl_start,
  input  rd_pkg::addr_t        ctrl_addr_offset,
  input  rd_pkg::xfer_size_t   ctrl_xfer_size_in_bytes,
  output rd_pkg::burst_plan_t  plan,
  output logic                 run_start
);

  //////////////////////////////
  // Stage one capture
  //////////////////////////////
  // Beat count minus one, before the split into bursts
  logic [rd_pkg::TOTAL_LEN_W-1:0] total_len_r;
  rd_pkg::addr_t                  addr_r;

  // Start strobe pipeline
  logic start_d1;
  logic start_d2;

  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole beats
      // A partial beat already counts as the extra one, so no minus one
      if (ctrl_xfer_size_in_bytes[rd_pkg::LOG_DW_BYTES-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size_in_bytes[rd_pkg::LOG_DW_BYTES +: rd_pkg::TOTAL_LEN_W];
      end else begin
        total_len_r <= ctrl_xfer_size_in_bytes[rd_pkg::LOG_DW_BYTES +: rd_pkg::TOTAL_LEN_W]
                       - 1'b1;
      end
      // Align down so no burst straddles a 1 KB boundary
      addr_r <= ctrl_addr_offset & ~rd_pkg::addr_t'(rd_pkg::BURST_BYTES - 1);
    end
  end

  //////////////////////////////
  // Stage two split
  //////////////////////////////
  // Upper bits give the index of the last burst
  // Lower bits give the length field of that burst
  always_ff @(posedge aclk) begin
    plan.base_addr <= addr_r;
    plan.last_txn  <= total_len_r[rd_pkg::LOG_BURST +: rd_pkg::TXN_W];
    plan.final_len <= total_len_r[0 +: rd_pkg::LOG_BURST];
  end

  //////////////////////////////
  // Run strobe
  //////////////////////////////
  // Three flops so the plan has a full cycle to settle before use
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1  <= 1'b0;
      start_d2  <= 1'b0;
      run_start <= 1'b0;
    end else begin
      start_d1  <= ctrl_start;
      start_d2  <= start_d1;
      run_start <= start_d2;
    end
  end

endmodule

/* logic/ar_issuer.sv */
// Issues the AR bursts of one command
// Every burst is full length except the last one
// No more than MAX_OUTSTANDING bursts wait for their rlast
// arvalid drops for at least one cycle after each accepted request
module ar_issuer (
  input  logic                 aclk,
  input  logic                 areset,
  input  rd_pkg::burst_plan_t  plan,
  input  logic                 run_start,
  input  logic                 burst_done,
  output logic                 arvalid,
  input  logic                 arready,
  output rd_pkg::ar_req_t      ar_req
);

  //////////////////////////////
  // Declarations
  //////////////////////////////
  // High when nothing is left to issue
  logic idle;
  // Request accepted this cycle
  logic arxfer;
  // Last burst of the command accepted
  logic ar_done;
  // Vacancy exhausted
  logic stall_ar;
  // True on the final burst
  logic final_txn;

  rd_pkg::addr_t      addr_r;
  // Bursts still to send after the current one
  rd_pkg::txn_cnt_t   txn_left;
  // Free outstanding slots
  rd_pkg::outst_cnt_t vacancy;

  assign arxfer    = arvalid & arready;
  assign final_txn = (txn_left == '0);
  assign ar_done   = arxfer & final_txn;
  assign stall_ar  = (vacancy == '0);

  //////////////////////////////
  // Request payload
  //////////////////////////////
  assign ar_req.addr = addr_r;
  // Remainder length only on the last burst
  assign ar_req.len  = final_txn ? plan.final_len
                                 : rd_pkg::arlen_t'(rd_pkg::BURST_BEATS - 1);

  //////////////////////////////
  // Valid and idle control
  //////////////////////////////
  // Raise only from low, then hold until accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid <= 1'b0;
    end else if (!idle && !stall_ar && !arvalid) begin
      arvalid <= 1'b1;
    end else if (arready) begin
      arvalid <= 1'b0;
    end
  end

  // Leave idle on the run strobe
  // return once the final request is taken
  always_ff @(posedge aclk) begin
    if (areset) begin
      idle <= 1'b1;
    end else if (run_start) begin
      idle <= 1'b0;
    end else if (ar_done) begin
      idle <= 1'b1;
    end
  end

  //////////////////////////////
  // Address and burst count
  //////////////////////////////
  // Address steps one burst at a time
  always_ff @(posedge aclk) begin
    if (run_start) begin
      addr_r <= plan.base_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + rd_pkg::addr_t'(rd_pkg::BURST_BYTES);
    end
  end

  // Counts down and parks at zero
  always_ff @(posedge aclk) begin
    if (areset) begin
      txn_left <= '0;
    end else if (run_start) begin
      txn_left <= plan.last_txn;
    end else if (arxfer && !final_txn) begin
      txn_left <= txn_left - 1'b1;
    end
  end

  //////////////////////////////
  // Outstanding limit
  //////////////////////////////
  // One slot taken per request, one freed per completed burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= rd_pkg::outst_cnt_t'(rd_pkg::MAX_OUTSTANDING);
    end else begin
      case ({arxfer, burst_done})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

endmodule

/* logic/r_tracker.sv */
// Passes R beats to the stream with no added latency
// rready is tready so the stream throttles the read channel
// ctrl_done pulses once, the cycle after the final rlast
module r_tracker (
  input  logic                 aclk,
  input  logic                 areset,
  input  rd_pkg::burst_plan_t  plan,
  input  logic                 run_start,
  input  logic                 rvalid,
  output logic                 rready,
  input  rd_pkg::r_beat_t      r_beat,
  output logic                 tvalid,
  input  logic                 tready,
  output rd_pkg::r_beat_t      t_beat,
  output logic                 burst_done,
  output logic                 ctrl_done
);

  //////////////////////////////
  // Stream pass-through
  //////////////////////////////
  // Bursts still to finish after the current one
  rd_pkg::txn_cnt_t r_left;
  logic             rxfer;
  logic             final_burst;

  assign tvalid = rvalid;
  assign t_beat = r_beat;
  assign rready = tready;

  // Beat taken on both sides in the same cycle
  assign rxfer = rvalid & tready;

  // A completed burst frees one outstanding slot
  assign burst_done  = rxfer & r_beat.last;
  assign final_burst = (r_left == '0);

  //////////////////////////////
  // Burst countdown
  //////////////////////////////
  // Loaded with the same count as the issuer
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_left <= '0;
    end else if (run_start) begin
      r_left <= plan.last_txn;
    end else if (burst_done && !final_burst) begin
      r_left <= r_left - 1'b1;
    end
  end

  //////////////////////////////
  // Done pulse
  //////////////////////////////
  // Set by the final rlast
  // falls again on the next edge
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= burst_done & final_burst;
    end
  end

endmodule

/* logic/axi_read_master.sv */
// AXI4 read master with an AXI4-Stream data output
// Single clock, no data FIFO, rready follows tready
// Start address is aligned down to 1 KB, byte count rounded up to beats
// Issue the next ctrl_start only after ctrl_done
module axi_read_master (
  input  logic                aclk,
  input  logic                areset,

  // Command side
  input  logic                ctrl_start,
  input  rd_pkg::addr_t       ctrl_addr_offset,
  input  rd_pkg::xfer_size_t  ctrl_xfer_size_in_bytes,
  output logic                ctrl_done,

  // AR channel
  output logic                m_axi_arvalid,
  input  logic                m_axi_arready,
  output rd_pkg::ar_req_t     m_axi_ar,

  // R channel
  input  logic                m_axi_rvalid,
  output logic                m_axi_rready,
  input  rd_pkg::r_beat_t     m_axi_r,

  // Stream output
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output rd_pkg::r_beat_t     m_axis_t
);

  //////////////////////////////
  // Internal wiring
  //////////////////////////////
  // Plan shared by issuer and tracker
  rd_pkg::burst_plan_t plan;
  logic                run_start;
  // One pulse per finished burst
  logic                burst_done;

  // Command capture and pre-processing
  rd_cmd_regs rd_cmd_regs_i (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .plan                    (plan),
    .run_start               (run_start)
  );

  // Address channel
  ar_issuer ar_issuer_i (
    .aclk       (aclk),
    .areset     (areset),
    .plan       (plan),
    .run_start  (run_start),
    .burst_done (burst_done),
    .arvalid    (m_axi_arvalid),
    .arready    (m_axi_arready),
    .ar_req     (m_axi_ar)
  );

  // Data channel and completion
  r_tracker r_tracker_i (
    .aclk       (aclk),
    .areset     (areset),
    .plan       (plan),
    .run_start  (run_start),
    .rvalid     (m_axi_rvalid),
    .rready     (m_axi_rready),
    .r_beat     (m_axi_r),
    .tvalid     (m_axis_tvalid),
    .tready     (m_axis_tready),
    .t_beat     (m_axis_t),
    .burst_done (burst_done),
    .ctrl_done  (ctrl_done)
  );

endmodule

/* sim/axi_slave_model.sv */
// Behavioral AXI4 read slave for the read master testbench
// Returns the byte address of each beat as its data
// Bursts are served in order, one beat per cycle at most
// arready and rvalid gaps come from the stall inputs
module axi_slave_model (
  input  logic             aclk,
  input  logic             areset,

  // Gap requests from the random driver
  input  logic             ar_stall,
  input  logic             r_stall,

  // AR channel
  input  logic             arvalid,
  output logic             arready,
  input  rd_pkg::ar_req_t  ar,

  // R channel
  output logic             rvalid,
  input  logic             rready,
  output rd_pkg::r_beat_t  r
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BEAT_BYTES  = 4;
  // Enough room for the four bursts the master may have in flight
  localparam int QUEUE_DEPTH = 8;

  //////////////////////////////
  // Request queue
  //////////////////////////////
  rd_pkg::ar_req_t req_q[$];
  // Beat position inside the burst at the head of the queue
  int   beat_idx   = 0;
  // R beat taken at the last rising edge
  logic beat_taken = 1'b0;
  // Gap requests as seen at the last rising edge
  logic ar_gap     = 1'b1;
  logic r_gap      = 1'b1;

  // Handshakes are seen at the rising edge, before the DUT updates
  always @(posedge aclk) begin
    ar_gap = ar_stall;
    r_gap  = r_stall;
    if (areset) begin
      req_q.delete();
      beat_idx   = 0;
      beat_taken = 1'b0;
    end else begin
      if (arvalid && arready) begin
        req_q.push_back(ar);
      end
      beat_taken = rvalid && rready;
      if (beat_taken) begin
        // Burst finished, move on to the next request
        if (beat_idx == int'(req_q[0].len)) begin
          void'(req_q.pop_front());
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
  end

  //////////////////////////////
  // Output drive
  //////////////////////////////
  // Outputs change on the falling edge only
  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
    forever begin
      @(negedge aclk);
      if (areset) begin
        arready = 1'b0;
        rvalid  = 1'b0;
      end else begin
        arready = !ar_gap && (req_q.size() < QUEUE_DEPTH);
        // A pending beat stays put until it is taken
        if (!rvalid || beat_taken) begin
          if ((req_q.size() > 0) && !r_gap) begin
            rvalid = 1'b1;
            r.data = req_q[0].addr + rd_pkg::addr_t'(beat_idx * BEAT_BYTES);
            r.last = (beat_idx == int'(req_q[0].len));
          end else begin
            rvalid = 1'b0;
          end
        end
      end
    end
  end

endmodule

/* sim/tb_axi_read_master.sv */
// Testbench for the AXI4 read master
// Expected bursts and beats follow from each command's offset and size
// Random gaps on arready, rvalid and tready come from one seeded stream
// Commands are issued one at a time, each after the previous done pulse
module tb_axi_read_master;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'h07bb4685;
  localparam int BEAT_BYTES = 4;
  localparam int FULL_BEATS = 256;
  localparam int BURST_STEP = 1024;
  localparam int MAX_OUTST  = 4;
  localparam int WAIT_LIMIT = 100000;

  logic aclk;
  logic areset;
  logic ctrl_start;
  logic [31:0] ctrl_addr_offset;
  logic [31:0] ctrl_xfer_size_in_bytes;
  logic ctrl_done;
  logic m_axi_arvalid;
  logic m_axi_arready;
  logic m_axi_rvalid;
  logic m_axi_rready;
  logic m_axis_tvalid;
  logic m_axis_tready;
  logic ar_stall;
  logic r_stall;
  rd_pkg::ar_req_t m_axi_ar;
  rd_pkg::r_beat_t m_axi_r;
  rd_pkg::r_beat_t m_axis_t;

  // Expected shape of the running command
  logic [31:0] cmd_base;
  int          cmd_beats;
  int          cmd_bursts;
  logic [7:0]  cmd_last_len;

  // Progress counters, updated at the rising edge
  int   ar_count;
  int   beat_count;
  int   outstanding;
  logic done_exp;

  logic        ar_hs;
  logic        t_hs;
  logic [31:0] exp_araddr;
  logic [7:0]  exp_arlen;
  logic [31:0] exp_tdata;
  logic        exp_tlast;

  axi_read_master axi_read_master_i (.*);

  axi_slave_model slave_i (
    .aclk(aclk), .areset(areset), .ar_stall(ar_stall), .r_stall(r_stall),
    .arvalid(m_axi_arvalid), .arready(m_axi_arready), .ar(m_axi_ar),
    .rvalid(m_axi_rvalid), .rready(m_axi_rready), .r(m_axi_r)
  );

  always #5 aclk = ~aclk;

  //////////////////////////////
  // Reference model
  //////////////////////////////
  assign ar_hs      = m_axi_arvalid && m_axi_arready;
  assign t_hs       = m_axis_tvalid && m_axis_tready;
  // Bursts step by 1 KB from the aligned base
  assign exp_araddr = cmd_base + 32'(ar_count) * BURST_STEP;
  assign exp_arlen  = (ar_count == cmd_bursts - 1) ? cmd_last_len : 8'(FULL_BEATS - 1);
  assign exp_tdata  = cmd_base + 32'(beat_count) * BEAT_BYTES;
  // Last beat of a full burst or of the whole command
  assign exp_tlast  = ((beat_count % FULL_BEATS) == FULL_BEATS - 1)
                      || (beat_count == cmd_beats - 1);

  always @(posedge aclk) begin
    if (areset) begin
      ar_count    <= 0;
      beat_count  <= 0;
      outstanding <= 0;
      done_exp    <= 1'b0;
    end else begin
      if (ctrl_start) begin
        ar_count   <= 0;
        beat_count <= 0;
      end else begin
        ar_count   <= ar_count + int'(ar_hs);
        beat_count <= beat_count + int'(t_hs);
      end
      outstanding <= outstanding + int'(ar_hs)
                     - int'(m_axi_rvalid && m_axi_rready && m_axi_r.last);
      done_exp    <= t_hs && (beat_count == cmd_beats - 1);
    end
  end

  //////////////////////////////
  // Failure reporting
  //////////////////////////////
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string test, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_run($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", test, expected, actual));
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////
  a_ar_addr: assert property (@(posedge aclk) disable iff (areset)
      ar_hs |-> m_axi_ar.addr == exp_araddr)
    else report_mismatch("ar_addr", $sampled(exp_araddr), $sampled(m_axi_ar.addr));
  a_ar_len: assert property (@(posedge aclk) disable iff (areset)
      ar_hs |-> m_axi_ar.len == exp_arlen)
    else report_mismatch("ar_len", $sampled(exp_arlen), $sampled(m_axi_ar.len));
  a_ar_count: assert property (@(posedge aclk) disable iff (areset)
      ar_hs |-> ar_count < cmd_bursts)
    else report_mismatch("ar_count", $sampled(cmd_bursts), $sampled(ar_count) + 1);
  a_t_data: assert property (@(posedge aclk) disable iff (areset)
      t_hs |-> m_axis_t.data == exp_tdata)
    else report_mismatch("t_data", $sampled(exp_tdata), $sampled(m_axis_t.data));
  a_t_last: assert property (@(posedge aclk) disable iff (areset)
      t_hs |-> m_axis_t.last == exp_tlast)
    else report_mismatch("t_last", $sampled(exp_tlast), $sampled(m_axis_t.last));
  a_t_count: assert property (@(posedge aclk) disable iff (areset)
      t_hs |-> beat_count < cmd_beats)
    else report_mismatch("t_count", $sampled(cmd_beats), $sampled(beat_count) + 1);
  // Stream mirrors R, and R is throttled by the stream
  a_t_beat: assert property (@(posedge aclk) disable iff (areset)
      m_axis_t == m_axi_r)
    else report_mismatch("t_beat", $sampled(m_axi_r), $sampled(m_axis_t));
  a_handshake: assert property (@(posedge aclk) disable iff (areset)
      {m_axis_tvalid, m_axi_rready} == {m_axi_rvalid, m_axis_tready})
    else report_mismatch("handshake", $sampled({m_axi_rvalid, m_axis_tready}),
                         $sampled({m_axis_tvalid, m_axi_rready}));
  a_outstanding: assert property (@(posedge aclk) disable iff (areset)
      outstanding <= MAX_OUTST)
    else report_mismatch("outstanding", MAX_OUTST, $sampled(outstanding));
  a_done: assert property (@(posedge aclk) disable iff (areset)
      ctrl_done == done_exp)
    else report_mismatch("done", $sampled(done_exp), $sampled(ctrl_done));

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic run_command(input logic [31:0] offset, input logic [31:0] size);
    int cycles;
    cmd_base     = offset & ~32'(BURST_STEP - 1);
    cmd_beats    = (size + BEAT_BYTES - 1) / BEAT_BYTES;
    cmd_bursts   = (cmd_beats + FULL_BEATS - 1) / FULL_BEATS;
    cmd_last_len = 8'((cmd_beats - 1) % FULL_BEATS);
    ctrl_addr_offset        = offset;
    ctrl_xfer_size_in_bytes = size;
    ctrl_start              = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
    cycles     = 0;
    while (!ctrl_done) begin
      @(negedge aclk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run($sformatf("Timed out waiting for done on %0d bytes at 0x%0h", size, offset));
      end
    end
    // Whole command seen by the time done pulses
    assert (ar_count == cmd_bursts) else report_mismatch("burst_total", cmd_bursts, ar_count);
    assert (beat_count == cmd_beats) else report_mismatch("beat_total", cmd_beats, beat_count);
    repeat (3) @(negedge aclk);
  endtask

  // Single seeded stream for every random gap
  initial begin
    void'($urandom(SEED));
    m_axis_tready = 1'b0;
    ar_stall      = 1'b1;
    r_stall       = 1'b1;
    forever begin
      @(negedge aclk);
      m_axis_tready = ($urandom % 4) != 0;
      ar_stall      = ($urandom % 3) == 0;
      r_stall       = ($urandom % 2) == 0;
    end
  end

  initial begin
    aclk                    = 1'b0;
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    cmd_base                = '0;
    cmd_beats               = 0;
    cmd_bursts              = 0;
    cmd_last_len            = '0;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
    repeat (4) @(negedge aclk);
    run_command(32'h0000_1234, 32'd100);
    run_command(32'h0000_0000, 32'd1024);
    run_command(32'h0000_8000, 32'd5000);
    // More than four bursts, so the outstanding limit engages
    run_command(32'h0004_0300, 32'd20000);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* src.f */
logic/rd_pkg.sv
logic/rd_cmd_regs.sv
logic/ar_issuer.sv
logic/r_tracker.sv
logic/axi_read_master.sv
sim/axi_slave_model.sv
sim/tb_axi_read_master.sv

/* Bender.yml */
package:
  name: axi_read_master

sources:
  - logic/rd_pkg.sv
  - logic/rd_cmd_regs.sv
  - logic/ar_issuer.sv
  - logic/r_tracker.sv
  - logic/axi_read_master.sv
  - target: simulation
    files:
      - sim/axi_slave_model.sv
      - sim/tb_axi_read_master.sv
